//--- testbench/fir_golden.txt
# T name gap | C addr re im | S re im count | E re im count | X ends the test
# Values in hex; gap (0 back-to-back, 1 random) and count in decimal
T zero_coef 1
S 123456 fedcba 3
S 0 0 29
E 0 0 32
X
T impulse_real 1
C 0 40000 0
C 7 c0000 0
C e 7ec0000 0
S 40 0 1
S 0 0 28
E 2 0 1
E 0 0 6
E 6 0 1
E 0 0 6
E fffffff6 0 1
E 0 0 6
E 6 0 1
E 0 0 6
E 2 0 1
X
T complex_cross 1
C 0 80000 c0000
C 7 0 0
C e 0 0
S 20 ffffc0 1
S ffffec 0 1
E 8 ffffffff 1
E ffffffff fffffffe 1
X
T back_pressure 0
S 20 0 5
S 40 0 5
E 2 3 5
E 4 6 5
X
T coef_reload 1
C 0 0 0
C e 40000 0
C f 123 0
S 0 0 5
E 0 0 2
E 1 fffffffe 1
E ffffffff 0 1
E 1 0 1
X

//--- list.f
rtl/fir_pkg.sv
rtl/sample_fifo.sv
rtl/coef_bank.sv
rtl/tap_sequencer.sv
rtl/complex_tap_lane.sv
rtl/phase_accumulator.sv
rtl/fir_complex_29.sv
testbench/tb_fir_complex_29.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f \
  --top-module tb_fir_complex_29 -o sim_fir

./obj_dir/sim_fir | tee sim.log

grep -q "Result: PASSED" sim.log

//--- testbench/tb_fir_complex_29.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir_complex_29;

  logic                             clk;
  logic                             RST;
  logic                             push;
  logic                             stop;
  logic [fir_pkg::SAMP_W-1:0]       samp_re;
  logic [fir_pkg::SAMP_W-1:0]       samp_im;
  logic                             coef_push;
  logic [fir_pkg::COEF_ADDR_W-1:0]  coef_addr;
  logic [fir_pkg::COEF_W-1:0]       coef_re;
  logic [fir_pkg::COEF_W-1:0]       coef_im;
  logic                             out_push;
  logic [fir_pkg::OUT_W-1:0]        out_re;
  logic [fir_pkg::OUT_W-1:0]        out_im;

  // Golden records with one entry per line of the file
  string       kind_q[$];
  string       name_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  logic [31:0] exp_re_q[$];
  logic [31:0] exp_im_q[$];

  string       cur_test;
  int          errors;
  int          checks;
  int          stalls;
  int          outputs;
  int          n_tests;
  int          total_ops;
  int          cycles;
  int          cycle_limit;
  logic [31:0] lfsr_state;
  int          fd;

  fir_complex_29 i_fir_complex_29 (
    .clk(clk), .RST(RST), .push_i(push), .stop_o(stop),
    .samp_re_i(samp_re), .samp_im_i(samp_im),
    .coef_push_i(coef_push), .coef_addr_i(coef_addr),
    .coef_re_i(coef_re), .coef_im_i(coef_im),
    .push_o(out_push), .out_re_o(out_re), .out_im_o(out_im)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles in test %s", cycles, cur_test);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  // Outputs are stable around the falling edge
  always @(negedge clk)
  begin
    if (!RST && out_push)
    begin
      outputs++;
      if (exp_re_q.size() == 0)
      begin
        errors++;
        $display("Test %s: extra output %h %h arrived with nothing expected",
                 cur_test, out_re, out_im);
      end
      else
      begin
        check_value({cur_test, " real"}, exp_re_q.pop_front(), out_re);
        check_value({cur_test, " imag"}, exp_im_q.pop_front(), out_im);
      end
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////
  // Galois LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic random_bits(input int n, output int v);
    v = 0;
    repeat (n)
    begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_sample(input logic [31:0] re, input logic [31:0] im);
    push    = 1'b1;
    samp_re = re[fir_pkg::SAMP_W-1:0];
    samp_im = im[fir_pkg::SAMP_W-1:0];
    while (stop)
    begin
      stalls++;
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    push = 1'b0;
  endtask

  task automatic write_coef(input logic [31:0] addr, input logic [31:0] re,
                            input logic [31:0] im);
    coef_push = 1'b1;
    coef_addr = addr[fir_pkg::COEF_ADDR_W-1:0];
    coef_re   = re[fir_pkg::COEF_W-1:0];
    coef_im   = im[fir_pkg::COEF_W-1:0];
    @(posedge clk);
    #2;
    coef_push = 1'b0;
  endtask

  task automatic read_golden();
    string       line;
    string       kind;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          cnt;
    while (!$feof(fd))
    begin
      line = "";
      kind = "";
      void'($fgets(line, fd));
      void'($sscanf(line, "%s", kind));
      if (kind == "T")
      begin
        void'($sscanf(line, "%s %s %d", kind, name, cnt));
        kind_q.push_back(kind);
        name_q.push_back(name);
        a_q.push_back(cnt);
        b_q.push_back(0);
        c_q.push_back(0);
      end
      else if (kind == "C")
      begin
        void'($sscanf(line, "%s %h %h %h", kind, a, b, c));
        kind_q.push_back(kind);
        name_q.push_back("");
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        total_ops++;
      end
      else if (kind == "S" || kind == "E")
      begin
        void'($sscanf(line, "%s %h %h %d", kind, a, b, cnt));
        kind_q.push_back(kind);
        name_q.push_back("");
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(cnt);
        if (kind == "S")
          total_ops += cnt;
      end
      else if (kind == "X")
      begin
        kind_q.push_back(kind);
        name_q.push_back("");
        a_q.push_back(0);
        b_q.push_back(0);
        c_q.push_back(0);
      end
    end
  endtask

  task automatic finish_test(input int gap_mode, input int err0);
    int guard;
    guard = 0;
    while (exp_re_q.size() > 0 && guard < 400)
    begin
      @(posedge clk);
      guard++;
    end
    // Room for a stray output to show up
    repeat (10) @(posedge clk);
    #2;
    if (exp_re_q.size() > 0)
    begin
      errors++;
      $display("Test %s: %0d expected outputs never arrived", cur_test, exp_re_q.size());
      exp_re_q.delete();
      exp_im_q.delete();
    end
    if (gap_mode == 0 && stalls == 0)
    begin
      errors++;
      $display("Test %s: stop_o never rose during back-to-back pushes", cur_test);
    end
    $display("Test %s: %s, %0d outputs, %0d stalls", cur_test,
             (errors == err0) ? "ok" : "failed", outputs, stalls);
  endtask

  task automatic run_tests();
    int gap_mode;
    int err0;
    int g;
    int j;
    for (int i = 0; i < kind_q.size(); i++)
    begin
      if (kind_q[i] == "T")
      begin
        cur_test = name_q[i];
        gap_mode = a_q[i];
        err0     = errors;
        stalls   = 0;
        outputs  = 0;
        n_tests++;
        // Queue the whole test's expected outputs up front
        j = i + 1;
        while (j < kind_q.size() && kind_q[j] != "X")
        begin
          if (kind_q[j] == "E")
          begin
            repeat (c_q[j])
            begin
              exp_re_q.push_back(a_q[j]);
              exp_im_q.push_back(b_q[j]);
            end
          end
          j++;
        end
      end
      else if (kind_q[i] == "C")
        write_coef(a_q[i], b_q[i], c_q[i]);
      else if (kind_q[i] == "S")
      begin
        repeat (c_q[i])
        begin
          if (gap_mode != 0)
          begin
            random_bits(2, g);
            repeat (g)
            begin
              @(posedge clk);
              #2;
            end
          end
          send_sample(a_q[i], b_q[i]);
        end
      end
      else if (kind_q[i] == "X")
        finish_test(gap_mode, err0);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    RST         = 1'b1;
    push        = 1'b0;
    samp_re     = '0;
    samp_im     = '0;
    coef_push   = 1'b0;
    coef_addr   = '0;
    coef_re     = '0;
    coef_im     = '0;
    errors      = 0;
    checks      = 0;
    stalls      = 0;
    outputs     = 0;
    n_tests     = 0;
    total_ops   = 0;
    cycles      = 0;
    cycle_limit = 100000;
    cur_test    = "reset";
    lfsr_state  = 32'h149a;
    fd = $fopen("testbench/fir_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the golden file testbench/fir_golden.txt");
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      read_golden();
      $fclose(fd);
      cycle_limit = 8 * total_ops + 200;
      repeat (16) @(posedge clk);
      #2;
      RST = 1'b0;
      check_value("reset push_o", 64'd0, {63'd0, out_push});
      check_value("reset stop_o", 64'd0, {63'd0, stop});
      run_tests();
      $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
      if (errors == 0)
        $display("Result: PASSED");
      else
        $display("Result: FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fir_complex_29.sv
`timescale 1ns/1ps
`default_nettype none

module fir_complex_29
(
  input  wire                              clk,
  input  wire                              RST,
  input  wire                              push_i,
  output logic                             stop_o,
  input  wire  [fir_pkg::SAMP_W-1:0]       samp_re_i,
  input  wire  [fir_pkg::SAMP_W-1:0]       samp_im_i,
  input  wire                              coef_push_i,
  input  wire  [fir_pkg::COEF_ADDR_W-1:0]  coef_addr_i,
  input  wire  [fir_pkg::COEF_W-1:0]       coef_re_i,
  input  wire  [fir_pkg::COEF_W-1:0]       coef_im_i,
  output logic                             push_o,
  output logic [fir_pkg::OUT_W-1:0]        out_re_o,
  output logic [fir_pkg::OUT_W-1:0]        out_im_o
);

  logic [fir_pkg::SAMP_W-1:0]                      fifo_re;
  logic [fir_pkg::SAMP_W-1:0]                      fifo_im;
  logic                                            fifo_empty;
  logic                                            pop;
  logic                                            accepted;
  logic [fir_pkg::PHASE_W-1:0]                     phase;
  logic                                            seq_valid;
  logic                                            seq_first;
  logic                                            seq_last;
  logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_a_re;
  logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_a_im;
  logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_b_re;
  logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_b_im;
  logic [fir_pkg::NUM_LANES*fir_pkg::COEF_W-1:0]   lane_coef_re;
  logic [fir_pkg::NUM_LANES*fir_pkg::COEF_W-1:0]   lane_coef_im;
  logic [fir_pkg::NUM_LANES*fir_pkg::ACC_W-1:0]    lane_re;
  logic [fir_pkg::NUM_LANES*fir_pkg::ACC_W-1:0]    lane_im;

  // Sample enters the FIFO this cycle
  assign accepted = push_i & ~stop_o;

  sample_fifo i_sample_fifo (
    .clk(clk), .RST(RST), .wr_i(push_i), .rd_i(pop),
    .wr_re_i(samp_re_i), .wr_im_i(samp_im_i),
    .rd_re_o(fifo_re), .rd_im_o(fifo_im),
    .empty_o(fifo_empty), .full_o(stop_o)
  );

  tap_sequencer i_tap_sequencer (
    .clk(clk), .RST(RST), .fifo_empty_i(fifo_empty),
    .fifo_re_i(fifo_re), .fifo_im_i(fifo_im), .pop_o(pop), .phase_o(phase),
    .valid_o(seq_valid), .first_o(seq_first), .last_o(seq_last),
    .tap_a_re_o(tap_a_re), .tap_a_im_o(tap_a_im),
    .tap_b_re_o(tap_b_re), .tap_b_im_o(tap_b_im)
  );

  coef_bank i_coef_bank (
    .clk(clk), .RST(RST), .coef_push_i(coef_push_i), .coef_addr_i(coef_addr_i),
    .coef_re_i(coef_re_i), .coef_im_i(coef_im_i), .copy_i(accepted),
    .phase_i(phase), .lane_coef_re_o(lane_coef_re), .lane_coef_im_o(lane_coef_im)
  );

  for (genvar j = 0; j < fir_pkg::NUM_LANES; j++)
  begin : g_lane
    complex_tap_lane i_complex_tap_lane (
      .clk(clk), .RST(RST),
      .a_re_i(tap_a_re[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W]),
      .a_im_i(tap_a_im[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W]),
      .b_re_i(tap_b_re[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W]),
      .b_im_i(tap_b_im[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W]),
      .coef_re_i(lane_coef_re[j*fir_pkg::COEF_W +: fir_pkg::COEF_W]),
      .coef_im_i(lane_coef_im[j*fir_pkg::COEF_W +: fir_pkg::COEF_W]),
      .prod_re_o(lane_re[j*fir_pkg::ACC_W +: fir_pkg::ACC_W]),
      .prod_im_o(lane_im[j*fir_pkg::ACC_W +: fir_pkg::ACC_W])
    );
  end

  phase_accumulator i_phase_accumulator (
    .clk(clk), .RST(RST), .valid_i(seq_valid), .first_i(seq_first),
    .last_i(seq_last), .lane_re_i(lane_re), .lane_im_i(lane_im),
    .push_o(push_o), .out_re_o(out_re_o), .out_im_o(out_im_o)
  );

endmodule

`default_nettype wire

//--- rtl/phase_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module phase_accumulator
(
  input  wire                                             clk,
  input  wire                                             RST,
  input  wire                                             valid_i,
  input  wire                                             first_i,
  input  wire                                             last_i,
  input  wire  [fir_pkg::NUM_LANES*fir_pkg::ACC_W-1:0]    lane_re_i,
  input  wire  [fir_pkg::NUM_LANES*fir_pkg::ACC_W-1:0]    lane_im_i,
  output logic                                            push_o,
  output logic [fir_pkg::OUT_W-1:0]                       out_re_o,
  output logic [fir_pkg::OUT_W-1:0]                       out_im_o
);

  // Flags trail the tap cycle by three stages
  logic [2:0]                valid_sr;
  logic [2:0]                first_sr;
  logic [2:0]                last_sr;
  logic [fir_pkg::ACC_W-1:0] group_re;
  logic [fir_pkg::ACC_W-1:0] group_im;
  logic [fir_pkg::ACC_W-1:0] sum_re_q;
  logic [fir_pkg::ACC_W-1:0] sum_im_q;
  logic [fir_pkg::ACC_W-1:0] acc_re_q;
  logic [fir_pkg::ACC_W-1:0] acc_im_q;
  logic [fir_pkg::ACC_W-1:0] rnd_re;
  logic [fir_pkg::ACC_W-1:0] rnd_im;

  always_comb
  begin
    group_re = '0;
    group_im = '0;
    for (int j = 0; j < fir_pkg::NUM_LANES; j++)
    begin
      group_re = group_re + lane_re_i[j*fir_pkg::ACC_W +: fir_pkg::ACC_W];
      group_im = group_im + lane_im_i[j*fir_pkg::ACC_W +: fir_pkg::ACC_W];
    end
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      valid_sr <= '0;
      first_sr <= '0;
      last_sr  <= '0;
      sum_re_q <= '0;
      sum_im_q <= '0;
      acc_re_q <= '0;
      acc_im_q <= '0;
      push_o   <= 1'b0;
    end
    else
    begin
      valid_sr <= {valid_sr[1:0], valid_i};
      first_sr <= {first_sr[1:0], first_i};
      last_sr  <= {last_sr[1:0], last_i};
      sum_re_q <= group_re;
      sum_im_q <= group_im;
      // Phase 0 loads, later phases add
      if (valid_sr[2])
      begin
        acc_re_q <= first_sr[2] ? sum_re_q : acc_re_q + sum_re_q;
        acc_im_q <= first_sr[2] ? sum_im_q : acc_im_q + sum_im_q;
      end
      push_o <= valid_sr[2] & last_sr[2];
    end
  end

  ////////////////////
  // Output rounding
  ////////////////////
  assign rnd_re = acc_re_q[fir_pkg::ACC_W-1] ? acc_re_q + fir_pkg::ACC_W'(fir_pkg::RND_NEG)
                                             : acc_re_q;
  assign rnd_im = acc_im_q[fir_pkg::ACC_W-1] ? acc_im_q + fir_pkg::ACC_W'(fir_pkg::RND_NEG)
                                             : acc_im_q;
  assign out_re_o = rnd_re[fir_pkg::OUT_SHIFT +: fir_pkg::OUT_W];
  assign out_im_o = rnd_im[fir_pkg::OUT_SHIFT +: fir_pkg::OUT_W];

endmodule

`default_nettype wire

//--- rtl/complex_tap_lane.sv
`timescale 1ns/1ps
`default_nettype none

module complex_tap_lane
(
  input  wire                               clk,
  input  wire                               RST,
  input  wire  signed [fir_pkg::SAMP_W-1:0] a_re_i,
  input  wire  signed [fir_pkg::SAMP_W-1:0] a_im_i,
  input  wire  signed [fir_pkg::SAMP_W-1:0] b_re_i,
  input  wire  signed [fir_pkg::SAMP_W-1:0] b_im_i,
  input  wire  signed [fir_pkg::COEF_W-1:0] coef_re_i,
  input  wire  signed [fir_pkg::COEF_W-1:0] coef_im_i,
  output logic signed [fir_pkg::ACC_W-1:0]  prod_re_o,
  output logic signed [fir_pkg::ACC_W-1:0]  prod_im_o
);

  logic signed [fir_pkg::PRE_W-1:0]  pre_re_q;
  logic signed [fir_pkg::PRE_W-1:0]  pre_im_q;
  logic signed [fir_pkg::PROD_W-1:0] full_re;
  logic signed [fir_pkg::PROD_W-1:0] full_im;

  // (a + jb)(c + jd) = (ac - bd) + j(bc + ad)
  assign full_re = pre_re_q * coef_re_i - pre_im_q * coef_im_i;
  assign full_im = pre_im_q * coef_re_i + pre_re_q * coef_im_i;

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      pre_re_q  <= '0;
      pre_im_q  <= '0;
      prod_re_o <= '0;
      prod_im_o <= '0;
    end
    else
    begin
      pre_re_q  <= a_re_i + b_re_i;
      pre_im_q  <= a_im_i + b_im_i;
      // Drop low product bits, sign-extend the rest
      prod_re_o <= {{(fir_pkg::ACC_W - fir_pkg::PROD_W + fir_pkg::PROD_SHIFT)
                     {full_re[fir_pkg::PROD_W-1]}},
                    full_re[fir_pkg::PROD_W-1:fir_pkg::PROD_SHIFT]};
      prod_im_o <= {{(fir_pkg::ACC_W - fir_pkg::PROD_W + fir_pkg::PROD_SHIFT)
                     {full_im[fir_pkg::PROD_W-1]}},
                    full_im[fir_pkg::PROD_W-1:fir_pkg::PROD_SHIFT]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/tap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tap_sequencer
(
  input  wire                                             clk,
  input  wire                                             RST,
  input  wire                                             fifo_empty_i,
  input  wire  [fir_pkg::SAMP_W-1:0]                      fifo_re_i,
  input  wire  [fir_pkg::SAMP_W-1:0]                      fifo_im_i,
  output logic                                            pop_o,
  output logic [fir_pkg::PHASE_W-1:0]                     phase_o,
  output logic                                            valid_o,
  output logic                                            first_o,
  output logic                                            last_o,
  output logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_a_re_o,
  output logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_a_im_o,
  output logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_b_re_o,
  output logic [fir_pkg::NUM_LANES*fir_pkg::SAMP_W-1:0]   tap_b_im_o
);

  // busy_q low is IDLE, otherwise phase_q is the running phase
  logic                         busy_q;
  logic [fir_pkg::PHASE_W-1:0]  phase_q;
  logic                         last_phase;
  logic [fir_pkg::SAMP_W-1:0]   dl_re [fir_pkg::NUM_TAPS];
  logic [fir_pkg::SAMP_W-1:0]   dl_im [fir_pkg::NUM_TAPS];

  assign last_phase = (phase_q == fir_pkg::NUM_PHASES - 1);

  // Pop from IDLE or at the end of phase 2
  assign pop_o   = ~fifo_empty_i & (~busy_q | last_phase);
  assign phase_o = phase_q;
  assign valid_o = busy_q;
  assign first_o = busy_q & (phase_q == '0);
  assign last_o  = busy_q & last_phase;

  ////////////////////
  // Phase FSM
  ////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      busy_q  <= 1'b0;
      phase_q <= '0;
    end
    else if (pop_o)
    begin
      busy_q  <= 1'b1;
      phase_q <= '0;
    end
    else if (busy_q && !last_phase)
      phase_q <= phase_q + 1'b1;
    else
    begin
      busy_q  <= 1'b0;
      phase_q <= '0;
    end
  end

  ////////////////////
  // Delay line with x[0] newest
  ////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
      begin
        dl_re[i] <= '0;
        dl_im[i] <= '0;
      end
    end
    else if (pop_o)
    begin
      for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--)
      begin
        dl_re[i] <= dl_re[i-1];
        dl_im[i] <= dl_im[i-1];
      end
      dl_re[0] <= fifo_re_i;
      dl_im[0] <= fifo_im_i;
    end
  end

  // Symmetric pairs x[5p+j] and x[28-5p-j]
  for (genvar j = 0; j < fir_pkg::NUM_LANES; j++)
  begin : g_tap
    assign tap_a_re_o[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W] =
      dl_re[phase_q*fir_pkg::NUM_LANES + j];
    assign tap_a_im_o[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W] =
      dl_im[phase_q*fir_pkg::NUM_LANES + j];
    // Center tap has no partner
    assign tap_b_re_o[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W] =
      (last_phase && j == fir_pkg::NUM_LANES - 1) ? '0 :
      dl_re[fir_pkg::NUM_TAPS - 1 - phase_q*fir_pkg::NUM_LANES - j];
    assign tap_b_im_o[j*fir_pkg::SAMP_W +: fir_pkg::SAMP_W] =
      (last_phase && j == fir_pkg::NUM_LANES - 1) ? '0 :
      dl_im[fir_pkg::NUM_TAPS - 1 - phase_q*fir_pkg::NUM_LANES - j];
  end

endmodule

`default_nettype wire

//--- rtl/coef_bank.sv
`timescale 1ns/1ps
`default_nettype none

module coef_bank
(
  input  wire                                              clk,
  input  wire                                              RST,
  input  wire                                              coef_push_i,
  input  wire  [fir_pkg::COEF_ADDR_W-1:0]                  coef_addr_i,
  input  wire  signed [fir_pkg::COEF_W-1:0]                coef_re_i,
  input  wire  signed [fir_pkg::COEF_W-1:0]                coef_im_i,
  input  wire                                              copy_i,
  input  wire  [fir_pkg::PHASE_W-1:0]                      phase_i,
  output logic [fir_pkg::NUM_LANES*fir_pkg::COEF_W-1:0]    lane_coef_re_o,
  output logic [fir_pkg::NUM_LANES*fir_pkg::COEF_W-1:0]    lane_coef_im_o
);

  logic [fir_pkg::COEF_W-1:0] wr_re [fir_pkg::NUM_COEF];
  logic [fir_pkg::COEF_W-1:0] wr_im [fir_pkg::NUM_COEF];
  logic [fir_pkg::COEF_W-1:0] act_re [fir_pkg::NUM_COEF];
  logic [fir_pkg::COEF_W-1:0] act_im [fir_pkg::NUM_COEF];

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < fir_pkg::NUM_COEF; k++)
      begin
        wr_re[k]  <= '0;
        wr_im[k]  <= '0;
        act_re[k] <= '0;
        act_im[k] <= '0;
      end
      lane_coef_re_o <= '0;
      lane_coef_im_o <= '0;
    end
    else
    begin
      // Address 15 has no slot
      if (coef_push_i && (coef_addr_i < fir_pkg::NUM_COEF))
      begin
        wr_re[coef_addr_i] <= coef_re_i;
        wr_im[coef_addr_i] <= coef_im_i;
      end
      // Accepted sample takes a snapshot of the write bank
      if (copy_i)
      begin
        act_re <= wr_re;
        act_im <= wr_im;
      end
      // Lane j in phase p uses coefficient 5p+j
      for (int j = 0; j < fir_pkg::NUM_LANES; j++)
      begin
        lane_coef_re_o[j*fir_pkg::COEF_W +: fir_pkg::COEF_W] <=
          act_re[phase_i*fir_pkg::NUM_LANES + j];
        lane_coef_im_o[j*fir_pkg::COEF_W +: fir_pkg::COEF_W] <=
          act_im[phase_i*fir_pkg::NUM_LANES + j];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
(
  input  wire                        clk,
  input  wire                        RST,
  input  wire                        wr_i,
  input  wire                        rd_i,
  input  wire  [fir_pkg::SAMP_W-1:0] wr_re_i,
  input  wire  [fir_pkg::SAMP_W-1:0] wr_im_i,
  output logic [fir_pkg::SAMP_W-1:0] rd_re_o,
  output logic [fir_pkg::SAMP_W-1:0] rd_im_o,
  output logic                       empty_o,
  output logic                       full_o
);

  logic [fir_pkg::SAMP_W-1:0]   mem_re [fir_pkg::FIFO_DEPTH];
  logic [fir_pkg::SAMP_W-1:0]   mem_im [fir_pkg::FIFO_DEPTH];
  logic [fir_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [fir_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [fir_pkg::FIFO_PTR_W:0]   count_q;
  logic                           wr_en;
  logic                           rd_en;

  assign full_o  = (count_q == fir_pkg::FIFO_DEPTH);
  assign empty_o = (count_q == '0);

  // Writes dropped when full, reads dropped when empty
  assign wr_en = wr_i & ~full_o;
  assign rd_en = rd_i & ~empty_o;

  // Head of queue is visible without a read
  assign rd_re_o = mem_re[rd_ptr_q];
  assign rd_im_o = mem_im[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem_re[wr_ptr_q] <= wr_re_i;
      mem_im[wr_ptr_q] <= wr_im_i;
    end
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous read and write leaves the count alone
      if (wr_en && !rd_en)
        count_q <= count_q + 1'b1;
      else if (rd_en && !wr_en)
        count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fir_pkg.sv
`default_nettype none

package fir_pkg;

  // Datapath widths
  localparam int SAMP_W     = 24;
  localparam int COEF_W     = 27;
  localparam int PRE_W      = 25;
  localparam int PROD_W     = 52;
  localparam int PROD_SHIFT = 18;
  localparam int ACC_W      = 38;
  localparam int OUT_W      = 32;
  localparam int OUT_SHIFT  = 5;
  localparam int RND_NEG    = 8;

  // Filter structure
  localparam int NUM_TAPS    = 29;
  localparam int NUM_COEF    = 15;
  localparam int COEF_ADDR_W = 4;
  localparam int NUM_LANES   = 5;
  localparam int NUM_PHASES  = 3;
  localparam int PHASE_W     = 2;

  // Input FIFO
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;

endpackage

`default_nettype wire
